/* verilog/game_rom_pkg.sv */
/*
 * Game ROM shared definitions
 * SDRAM region map, loader PROM boundary, slot identifiers and arbiter states
 */
package game_rom_pkg;

    // SDRAM regions, as halfword offsets
    localparam logic [21:0] MAIN_START = 22'h00000;
    localparam logic [21:0] SND_START  = 22'h08000;
    localparam logic [21:0] SCR_START  = 22'h09000;
    localparam logic [21:0] OBJ_START  = 22'h11000;
    // First halfword past the object graphics
    localparam logic [21:0] OBJ_END    = 22'h19000;

    // Colour PROMs, as a loader byte address
    localparam logic [24:0] PROM_START = 25'h32000;

    // ROM clients, highest priority first
    typedef enum logic [1:0] {
        SLOT_SCR  = 2'd0,
        SLOT_OBJ  = 2'd1,
        SLOT_SND  = 2'd2,
        SLOT_MAIN = 2'd3
    } slot_id_e;

    // Burst sequencing on the SDRAM read port
    typedef enum logic [1:0] {
        ARB_IDLE     = 2'd0,
        ARB_WAIT_ACK = 2'd1,
        ARB_WAIT_DST = 2'd2,
        ARB_WAIT_RDY = 2'd3
    } arb_state_e;

endpackage

/* verilog/rom_dwnld.sv */
/*
 * ROM download
 * Turns loader bytes into SDRAM byte writes or colour PROM strobes,
 * swizzles graphics addresses and captures the hardware variant flag
 */
module rom_dwnld
    import game_rom_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    output logic [21:0] prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    output logic        prom_we,
    output logic        is_hyper
);
    logic        wr_en;
    logic        is_prom;
    logic        is_scr;
    logic        is_obj;
    logic [21:0] hw_addr;
    logic [21:0] gfx_addr;

    assign wr_en   = downloading && ioctl_wr;
    assign hw_addr = ioctl_addr[22:1];
    assign is_prom = ioctl_addr >= PROM_START;
    assign is_scr  = (hw_addr >= SCR_START) && (hw_addr < OBJ_START);
    assign is_obj  = (hw_addr >= OBJ_START) && (hw_addr < OBJ_END);

    // Graphics interleave keeps a tile row in one burst
    always_comb begin
        gfx_addr = hw_addr;
        if (is_scr) begin
            gfx_addr[3:0] = {hw_addr[2:0], ~hw_addr[3]};
        end else if (is_obj) begin
            gfx_addr[4:0] = {hw_addr[2:0], ~hw_addr[4], ~hw_addr[3]};
        end
    end

    // Write payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            prog_data <= ioctl_dout;
            // Active low mask with even bytes in the upper lane
            prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
            if (is_prom) begin
                prog_addr <= 22'(ioctl_addr - PROM_START);
            end else begin
                prog_addr <= gfx_addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we  <= 1'b0;
            prom_we  <= 1'b0;
            is_hyper <= 1'b0;
        end else begin
            // PROM strobe is a single cycle
            prom_we <= wr_en && is_prom;

            // SDRAM write held until the controller takes it
            if (wr_en && !is_prom) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;
            end

            // Second PROM byte tells the board variant apart
            if (wr_en && (ioctl_addr == PROM_START + 25'd1)) begin
                is_hyper <= &ioctl_dout;
            end
        end
    end

endmodule

/* verilog/rom_slot.sv */
/*
 * ROM client slot
 * One-line cache of a 32-bit SDRAM burst, answering hits in the same cycle
 * and requesting a fill from the arbiter on a miss
 */
module rom_slot #(
    parameter int ADDR_W = 14,
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cs,
    input  logic [ADDR_W-1:0] addr,
    output logic [DATA_W-1:0] data,
    output logic              ok,
    input  logic [21:0]       offset,
    output logic              fill_req,
    output logic [21:0]       fill_addr,
    input  logic              fill_we,
    input  logic              fill_hi,
    input  logic [15:0]       fill_data
);
    logic [ADDR_W-1:0] line;
    logic [ADDR_W-1:0] tag;
    logic [ADDR_W-1:0] req_line;
    logic              valid;
    logic              hit;
    logic              miss;
    logic [31:0]       line_buf;

    // Byte clients see four bytes per line
    assign line = (DATA_W == 32) ? addr : (addr >> 2);
    assign hit  = valid && (tag == line);
    assign miss = cs && !hit && !fill_req;
    assign ok   = cs && hit;

    // Two halfwords per line
    assign fill_addr = offset + 22'({req_line, 1'b0});

    generate
        if (DATA_W == 32) begin : g_word
            assign data = line_buf;
        end else begin : g_byte
            // Byte 0 is the low byte of the first halfword
            assign data = DATA_W'(line_buf >> {addr[1:0], 3'b000});
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= 1'b0;
            fill_req <= 1'b0;
        end else begin
            // Line is torn once the first half lands
            if (fill_we && !fill_hi) begin
                valid <= 1'b0;
            end
            if (fill_we && fill_hi) begin
                valid    <= 1'b1;
                fill_req <= 1'b0;
            end else if (miss) begin
                fill_req <= 1'b1;
            end
        end
    end

    // Requested line is frozen so a moving address refetches later
    always_ff @(posedge clk) begin
        if (miss) begin
            req_line <= line;
        end
        if (fill_we && !fill_hi) begin
            line_buf[15:0] <= fill_data;
        end
        if (fill_we && fill_hi) begin
            line_buf[31:16] <= fill_data;
            tag             <= req_line;
        end
    end

endmodule

/* verilog/rom_arbiter.sv */
/*
 * ROM fetch arbiter
 * Serves slot fills by fixed priority, one two-halfword SDRAM burst at a time
 */
module rom_arbiter
    import game_rom_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  logic [3:0]  req,
    input  logic [21:0] addr_scr,
    input  logic [21:0] addr_obj,
    input  logic [21:0] addr_snd,
    input  logic [21:0] addr_main,
    output logic [3:0]  we,
    output logic        hi,
    output logic [15:0] fill_data,
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_dst,
    input  logic        data_rdy,
    input  logic [15:0] data_read
);
    arb_state_e  state;
    slot_id_e    sel;
    slot_id_e    next_sel;
    logic [21:0] next_addr;

    // Lowest slot id wins
    always_comb begin
        if (req[SLOT_SCR]) begin
            next_sel = SLOT_SCR;
        end else if (req[SLOT_OBJ]) begin
            next_sel = SLOT_OBJ;
        end else if (req[SLOT_SND]) begin
            next_sel = SLOT_SND;
        end else begin
            next_sel = SLOT_MAIN;
        end
    end

    always_comb begin
        case (next_sel)
            SLOT_SCR: next_addr = addr_scr;
            SLOT_OBJ: next_addr = addr_obj;
            SLOT_SND: next_addr = addr_snd;
            default:  next_addr = addr_main;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ARB_IDLE;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // Download owns the SDRAM while it runs
                    if (|req && !downloading) begin
                        sdram_req <= 1'b1;
                        state     <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ARB_WAIT_DST;
                    end
                end
                ARB_WAIT_DST: begin
                    if (data_dst) begin
                        state <= ARB_WAIT_RDY;
                    end
                end
                ARB_WAIT_RDY: begin
                    if (data_rdy) begin
                        state <= ARB_IDLE;
                    end
                end
            endcase
        end
    end

    // Grant latched while idle, held for the whole burst
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            sel        <= next_sel;
            sdram_addr <= next_addr;
        end
    end

    // Halfword steering to the granted slot
    assign fill_data = data_read;
    assign hi        = (state == ARB_WAIT_RDY);

    always_comb begin
        we = '0;
        if ((state == ARB_WAIT_DST && data_dst) || (state == ARB_WAIT_RDY && data_rdy)) begin
            we[sel] = 1'b1;
        end
    end

endmodule

/* verilog/game_rom.sv */
/*
 * Game ROM subsystem
 * Loader download into SDRAM and colour PROMs, plus four cached ROM
 * clients sharing one SDRAM read port
 */
module game_rom
    import game_rom_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Loader
    input  logic        downloading,
    input  logic        ioctl_wr,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    output logic [21:0] prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    output logic        prom_we,
    output logic        is_hyper,
    output logic        dwnld_busy,
    // ROM clients
    input  logic        scr_cs,
    input  logic [13:0] scr_addr,
    output logic [31:0] scr_data,
    output logic        scr_ok,
    input  logic        obj_cs,
    input  logic [13:0] obj_addr,
    output logic [31:0] obj_data,
    output logic        obj_ok,
    input  logic        snd_cs,
    input  logic [12:0] snd_addr,
    output logic [7:0]  snd_data,
    output logic        snd_ok,
    input  logic        main_cs,
    input  logic [15:0] main_addr,
    output logic [7:0]  main_data,
    output logic        main_ok,
    // SDRAM read port
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_dst,
    input  logic        data_rdy,
    input  logic [15:0] data_read
);
    logic [3:0]  fill_req;
    logic [3:0]  fill_we;
    logic        fill_hi;
    logic [15:0] fill_data;
    logic [21:0] scr_fill_addr;
    logic [21:0] obj_fill_addr;
    logic [21:0] snd_fill_addr;
    logic [21:0] main_fill_addr;

    assign dwnld_busy = downloading;

    rom_dwnld u_dwnld (
        .clk        (clk),          .rst        (rst),
        .downloading(downloading),  .ioctl_wr   (ioctl_wr),
        .sdram_ack  (sdram_ack),    .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout),   .prog_addr  (prog_addr),
        .prog_data  (prog_data),    .prog_mask  (prog_mask),
        .prog_we    (prog_we),      .prom_we    (prom_we),
        .is_hyper   (is_hyper)
    );

    rom_slot #(.ADDR_W(14), .DATA_W(32)) u_scr (
        .clk      (clk),                 .rst      (rst),
        .cs       (scr_cs),              .addr     (scr_addr),
        .data     (scr_data),            .ok       (scr_ok),
        .offset   (SCR_START),           .fill_req (fill_req[SLOT_SCR]),
        .fill_addr(scr_fill_addr),       .fill_we  (fill_we[SLOT_SCR]),
        .fill_hi  (fill_hi),             .fill_data(fill_data)
    );

    rom_slot #(.ADDR_W(14), .DATA_W(32)) u_obj (
        .clk      (clk),                 .rst      (rst),
        .cs       (obj_cs),              .addr     (obj_addr),
        .data     (obj_data),            .ok       (obj_ok),
        .offset   (OBJ_START),           .fill_req (fill_req[SLOT_OBJ]),
        .fill_addr(obj_fill_addr),       .fill_we  (fill_we[SLOT_OBJ]),
        .fill_hi  (fill_hi),             .fill_data(fill_data)
    );

    // Sound CPU
    rom_slot #(.ADDR_W(13), .DATA_W(8)) u_snd (
        .clk      (clk),                 .rst      (rst),
        .cs       (snd_cs),              .addr     (snd_addr),
        .data     (snd_data),            .ok       (snd_ok),
        .offset   (SND_START),           .fill_req (fill_req[SLOT_SND]),
        .fill_addr(snd_fill_addr),       .fill_we  (fill_we[SLOT_SND]),
        .fill_hi  (fill_hi),             .fill_data(fill_data)
    );

    // Main CPU
    rom_slot #(.ADDR_W(16), .DATA_W(8)) u_main (
        .clk      (clk),                 .rst      (rst),
        .cs       (main_cs),             .addr     (main_addr),
        .data     (main_data),           .ok       (main_ok),
        .offset   (MAIN_START),          .fill_req (fill_req[SLOT_MAIN]),
        .fill_addr(main_fill_addr),      .fill_we  (fill_we[SLOT_MAIN]),
        .fill_hi  (fill_hi),             .fill_data(fill_data)
    );

    rom_arbiter u_arbiter (
        .clk        (clk),              .rst        (rst),
        .downloading(downloading),      .req        (fill_req),
        .addr_scr   (scr_fill_addr),    .addr_obj   (obj_fill_addr),
        .addr_snd   (snd_fill_addr),    .addr_main  (main_fill_addr),
        .we         (fill_we),          .hi         (fill_hi),
        .fill_data  (fill_data),        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),       .sdram_ack  (sdram_ack),
        .data_dst   (data_dst),         .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

endmodule

/* dv/game_rom_assertions.sv */
/*
 * Game ROM protocol assertions
 * SDRAM request hold, download exclusion and PROM strobe width
 */
module game_rom_assertions (
    input logic        clk,
    input logic        rst,
    input logic        downloading,
    input logic        sdram_req,
    input logic        sdram_ack,
    input logic [21:0] sdram_addr,
    input logic        prom_we
);
    int fail_count = 0;

    // Request and address stay put until the SDRAM takes them
    req_hold: assert property (@(posedge clk) disable iff (rst)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else begin
            fail_count++;
            $error("sdram_req or sdram_addr changed before sdram_ack");
        end

    // Loader owns the SDRAM during a download
    no_req_in_download: assert property (@(posedge clk) disable iff (rst)
        $rose(sdram_req) |-> !$past(downloading))
        else begin
            fail_count++;
            $error("sdram_req raised while downloading");
        end

    prom_pulse: assert property (@(posedge clk) disable iff (rst)
        prom_we |=> !prom_we)
        else begin
            fail_count++;
            $error("prom_we held for more than one cycle");
        end

endmodule

bind game_rom game_rom_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .downloading(downloading),
    .sdram_req  (sdram_req),
    .sdram_ack  (sdram_ack),
    .sdram_addr (sdram_addr),
    .prom_we    (prom_we)
);

/* dv/tb_game_rom.sv */
/*
 * Game ROM testbench
 * Directed tests of the loader download path and the cached ROM fetch path
 */
module tb_game_rom
    import game_rom_pkg::*;
();
    localparam int RESET_CYCLES = 16;
    localparam int FETCH_LIMIT  = 100;
    // Reset, download, prom, single miss, hit, all miss, download hold
    localparam int RUN_BUDGET   = 20 + 200 + 100 + 300 + 150 + 300 + 250;

    logic        clk;
    logic        rst;
    logic        downloading, ioctl_wr;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout, prog_data;
    logic [21:0] prog_addr, sdram_addr;
    logic [1:0]  prog_mask;
    logic        prog_we, prom_we, is_hyper, dwnld_busy;
    // Slot signals indexed by slot id
    logic [3:0]  cs, ok;
    logic [15:0] addr [4];
    logic [31:0] scr_data, obj_data;
    logic [7:0]  snd_data, main_data;
    logic        sdram_req, sdram_ack, data_dst, data_rdy;
    logic [15:0] data_read;
    logic [31:0] rng;
    logic [21:0] read_log [$];
    int          write_acks, errors, test_errors, tests, failed;
    string       test_name;

    game_rom u_dut (
        .clk(clk), .rst(rst), .downloading(downloading), .ioctl_wr(ioctl_wr),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .prog_addr(prog_addr),
        .prog_data(prog_data), .prog_mask(prog_mask), .prog_we(prog_we),
        .prom_we(prom_we), .is_hyper(is_hyper), .dwnld_busy(dwnld_busy),
        .scr_cs(cs[0]), .scr_addr(addr[0][13:0]), .scr_data(scr_data), .scr_ok(ok[0]),
        .obj_cs(cs[1]), .obj_addr(addr[1][13:0]), .obj_data(obj_data), .obj_ok(ok[1]),
        .snd_cs(cs[2]), .snd_addr(addr[2][12:0]), .snd_data(snd_data), .snd_ok(ok[2]),
        .main_cs(cs[3]), .main_addr(addr[3]), .main_data(main_data), .main_ok(ok[3]),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .data_dst(data_dst), .data_rdy(data_rdy), .data_read(data_read)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Content rule of the SDRAM model
    function automatic logic [15:0] rom_word(input logic [21:0] a);
        return a[15:0] ^ 16'hA5C3;
    endfunction

    function automatic logic [21:0] line_addr(input int slot, input logic [15:0] a);
        case (slot)
            0:       return SCR_START + {a[13:0], 1'b0};
            1:       return OBJ_START + {a[13:0], 1'b0};
            2:       return SND_START + {a[12:2], 1'b0};
            default: return MAIN_START + {a[15:2], 1'b0};
        endcase
    endfunction

    function automatic logic [31:0] expect_data(input int slot, input logic [15:0] a);
        logic [21:0] la;
        logic [31:0] line;
        la   = line_addr(slot, a);
        line = {rom_word(la + 22'd1), rom_word(la)};
        if (slot < 2)
            return line;
        return {24'd0, line[8*a[1:0] +: 8]};
    endfunction

    function automatic logic [31:0] slot_data(input int slot);
        case (slot)
            0:       return scr_data;
            1:       return obj_data;
            2:       return {24'd0, snd_data};
            default: return {24'd0, main_data};
        endcase
    endfunction

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR %s: %s", test_name, what);
        errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors > test_errors)
            failed++;
        $display("test %-14s %s", test_name, (errors > test_errors) ? "FAIL" : "ok");
    endtask

    // Acks reads and download writes, then returns the two halfwords of a read
    initial begin : sdram_model
        logic [21:0] a;
        logic        rd;
        sdram_ack  = 1'b0;
        data_dst   = 1'b0;
        data_rdy   = 1'b0;
        data_read  = '0;
        write_acks = 0;
        rng        = 32'h6736_4d67;
        forever begin
            wait_cycle();
            if (!rst && (sdram_req || prog_we)) begin
                rd  = sdram_req;
                a   = sdram_addr;
                rng = next_random(rng);
                repeat (rng[1:0]) wait_cycle();
                sdram_ack = 1'b1;
                wait_cycle();
                sdram_ack = 1'b0;
                if (rd) begin
                    read_log.push_back(a);
                    repeat (rng[3:2]) wait_cycle();
                    data_dst  = 1'b1;
                    data_read = rom_word(a);
                    wait_cycle();
                    data_dst = 1'b0;
                    repeat (rng[5:4]) wait_cycle();
                    data_rdy  = 1'b1;
                    data_read = rom_word(a + 22'd1);
                    wait_cycle();
                    data_rdy = 1'b0;
                end else begin
                    write_acks++;
                end
            end
        end
    end

    task automatic load_byte(input logic [24:0] a, input logic [7:0] d,
                             input logic [21:0] exp_addr, input logic [1:0] exp_mask);
        int acks;
        int n;
        acks = write_acks;
        wait_cycle();
        downloading = 1'b1;
        ioctl_wr    = 1'b1;
        ioctl_addr  = a;
        ioctl_dout  = d;
        wait_cycle();
        ioctl_wr = 1'b0;
        #1;
        if (dwnld_busy !== 1'b1)
            report_failure("dwnld_busy low while downloading");
        if (prog_addr !== exp_addr)
            report_mismatch($sformatf("prog_addr for %h", a), exp_addr, prog_addr);
        if (prog_data !== d)
            report_mismatch($sformatf("prog_data for %h", a), d, prog_data);
        if (a >= PROM_START) begin
            if (prom_we !== 1'b1 || prog_we !== 1'b0)
                report_failure($sformatf("PROM write at %h did not strobe prom_we alone", a));
            wait_cycle();
            #1;
            if (prom_we !== 1'b0)
                report_failure("prom_we lasted more than one cycle");
        end else begin
            if (prog_mask !== exp_mask)
                report_mismatch($sformatf("prog_mask for %h", a), exp_mask, prog_mask);
            if (prog_we !== 1'b1)
                report_failure($sformatf("prog_we did not rise after write at %h", a));
            n = 0;
            while (prog_we === 1'b1 && n < 20) begin
                wait_cycle();
                #1;
                n++;
            end
            if (prog_we !== 1'b0)
                report_failure("prog_we never dropped");
            else if (write_acks != acks + 1)
                report_failure("prog_we dropped without an SDRAM ack");
        end
    endtask

    task automatic fetch_check(input int slot, input logic [15:0] a, input bit want_hit);
        int          n;
        logic [31:0] exp;
        exp = expect_data(slot, a);
        wait_cycle();
        cs[slot]   = 1'b1;
        addr[slot] = a;
        #1;
        n = 0;
        while (ok[slot] !== 1'b1 && n < FETCH_LIMIT) begin
            wait_cycle();
            #1;
            n++;
        end
        if (ok[slot] !== 1'b1) begin
            report_failure($sformatf("slot %0d address %h got no ok in time", slot, a));
        end else begin
            if (slot_data(slot) !== exp)
                report_mismatch($sformatf("slot %0d data at %h", slot, a), exp,
                                slot_data(slot));
            if (want_hit && n != 0)
                report_failure($sformatf("slot %0d address %h missed instead of hit", slot, a));
        end
        wait_cycle();
        cs[slot] = 1'b0;
    endtask

    task automatic test_reset();
        start_test("reset");
        // Every client asks in the last reset cycle and no slot may answer
        cs = 4'hF;
        #1;
        if (ok !== 4'b0000)
            report_failure("slot answered before any fill");
        wait_cycle();
        rst = 1'b0;
        cs  = 4'h0;
        #1;
        if (sdram_req !== 1'b0 || prog_we !== 1'b0 || prom_we !== 1'b0)
            report_failure("strobes not low after reset");
        if (ok !== 4'b0000 || is_hyper !== 1'b0)
            report_failure("ok or is_hyper not low after reset");
        end_test();
    endtask

    task automatic test_download();
        start_test("download");
        load_byte(25'h00123, 8'h5E, 22'h00091, 2'b10);
        load_byte(25'h10004, 8'h11, 22'h08002, 2'b01);
        load_byte(25'h1200A, 8'hA7, 22'h0900B, 2'b01);
        load_byte(25'h22035, 8'h3C, 22'h11008, 2'b10);
        load_byte(25'h31FFE, 8'hC4, 22'h18FFC, 2'b01);
        downloading = 1'b0;
        #1;
        if (dwnld_busy !== 1'b0)
            report_failure("dwnld_busy still high after download");
        end_test();
    endtask

    task automatic test_prom();
        start_test("prom");
        load_byte(PROM_START + 25'd5, 8'h96, 22'h00005, 2'b00);
        load_byte(PROM_START + 25'd1, 8'hFF, 22'h00001, 2'b00);
        if (is_hyper !== 1'b1)
            report_mismatch("is_hyper after all ones", 1, is_hyper);
        load_byte(PROM_START + 25'd1, 8'h5A, 22'h00001, 2'b00);
        if (is_hyper !== 1'b0)
            report_mismatch("is_hyper after other value", 0, is_hyper);
        downloading = 1'b0;
        end_test();
    endtask

    task automatic test_single_miss();
        start_test("single_miss");
        fetch_check(0, 16'h0005, 1'b0);
        fetch_check(1, 16'h3FFF, 1'b0);
        fetch_check(2, 16'h0007, 1'b0);
        fetch_check(3, 16'hABCD, 1'b0);
        end_test();
    endtask

    task automatic test_hit();
        int n0;
        start_test("hit");
        n0 = read_log.size();
        fetch_check(3, 16'hABCD, 1'b1);
        fetch_check(3, 16'hABCE, 1'b1);
        if (read_log.size() != n0)
            report_failure("cached line issued a new sdram_req");
        fetch_check(3, 16'hABD0, 1'b0);
        if (read_log.size() != n0 + 1)
            report_mismatch("bursts for a new line", 1, read_log.size() - n0);
        else if (read_log[n0] !== line_addr(3, 16'hABD0))
            report_mismatch("burst address", line_addr(3, 16'hABD0), read_log[n0]);
        end_test();
    endtask

    task automatic test_all_miss();
        int          n0;
        logic [15:0] a [4];
        start_test("all_miss");
        a  = '{16'h0100, 16'h0040, 16'h0100, 16'h1234};
        n0 = read_log.size();
        fork
            fetch_check(0, a[0], 1'b0);
            fetch_check(1, a[1], 1'b0);
            fetch_check(2, a[2], 1'b0);
            fetch_check(3, a[3], 1'b0);
        join
        if (read_log.size() != n0 + 4) begin
            report_mismatch("burst count", 4, read_log.size() - n0);
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (read_log[n0 + i] !== line_addr(i, a[i]))
                    report_mismatch($sformatf("burst %0d address", i), line_addr(i, a[i]),
                                    read_log[n0 + i]);
            end
        end
        end_test();
    endtask

    task automatic test_download_hold();
        int n0;
        start_test("download_hold");
        n0 = read_log.size();
        wait_cycle();
        downloading = 1'b1;
        fork
            fetch_check(0, 16'h0222, 1'b0);
            fetch_check(2, 16'h0A01, 1'b0);
            begin
                repeat (20) wait_cycle();
                #1;
                if (sdram_req !== 1'b0 || read_log.size() != n0)
                    report_failure("SDRAM read issued while downloading");
                downloading = 1'b0;
            end
        join
        end_test();
    endtask

    initial begin : watchdog
        repeat (RESET_CYCLES + RUN_BUDGET) @(posedge clk);
        $display("TIMEOUT: run did not finish within %0d cycles", RESET_CYCLES + RUN_BUDGET);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        cs          = '0;
        addr        = '{default: '0};
        errors      = 0;
        tests       = 0;
        failed      = 0;
        repeat (RESET_CYCLES - 1) wait_cycle();
        test_reset();
        test_download();
        test_prom();
        test_single_miss();
        test_hit();
        test_all_miss();
        test_download_hold();
        errors += u_dut.u_assertions.fail_count;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", tests, failed,
                 errors, u_dut.u_assertions.fail_count);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* project.f */
verilog/game_rom_pkg.sv
verilog/rom_dwnld.sv
verilog/rom_slot.sv
verilog/rom_arbiter.sv
verilog/game_rom.sv
dv/game_rom_assertions.sv
dv/tb_game_rom.sv

/* Bender.yml */
package:
  name: game_rom

sources:
  # RTL, package first
  - files:
      - verilog/game_rom_pkg.sv
      - verilog/rom_dwnld.sv
      - verilog/rom_slot.sv
      - verilog/rom_arbiter.sv
      - verilog/game_rom.sv

  # Testbench and bound assertions
  - target: test
    files:
      - dv/game_rom_assertions.sv
      - dv/tb_game_rom.sv
